// ==== i8080_settings.svh ====
`ifndef I8080_SETTINGS_SVH
`define I8080_SETTINGS_SVH

// bus widths
`define XLEN 8
`define ALEN 16

// flag register bit positions
`define FLAG_C 0
`define FLAG_P 2
`define FLAG_Z 6
`define FLAG_S 7

// aux carry at bit 4 is never set
`define FLAGS_RESET 8'b0000_0010  // bit 1 always reads as one

`endif

// ==== i8080_pkg.sv ====
package i8080_pkg;

  typedef enum logic [2:0] {t1, t2, t3, t4, t5, tw, tr} tstate_e;

  typedef enum logic [1:0] {m1, m2, m3, m4} mcycle_e;

  typedef enum logic [3:0] {
    ic_nop, ic_mov, ic_mvi, ic_lxi, ic_lda, ic_sta,
    ic_alu_reg, ic_alu_imm, ic_inr, ic_dcr, ic_jmp
  } instr_class_e;

  // first eight follow the opcode alu field
  typedef enum logic [3:0] {
    alu_add, alu_adc, alu_sub, alu_sbb, alu_ana, alu_xra, alu_ora, alu_cmp,
    alu_inr, alu_dcr
  } alu_op_e;

  // b..l and a match the opcode register field
  typedef enum logic [3:0] {
    reg_b = 4'd0, reg_c = 4'd1, reg_d = 4'd2, reg_e = 4'd3,
    reg_h = 4'd4, reg_l = 4'd5, reg_w = 4'd6, reg_a = 4'd7, reg_z = 4'd8
  } reg_sel_e;

  typedef enum logic [2:0] {pair_bc, pair_de, pair_hl, pair_sp, pair_wz, pair_pc} pair_sel_e;

  typedef enum logic [2:0] {bus_data_in, bus_reg, bus_a, bus_tmp, bus_alu} bus_src_e;

  typedef struct packed {
    instr_class_e instr_class;
    logic [2:0]   sss;
    logic [2:0]   ddd;
    logic [1:0]   rp;
    alu_op_e      alu_op;
    logic         branch_taken;
  } decoded_t;

  typedef struct packed {
    bus_src_e  bus_src;
    reg_sel_e  reg_sel;
    logic      write_reg;
    pair_sel_e pair_sel;
    logic      inc_pair;
    logic      pc_from_wz;
    logic      write_a;
    logic      a_from_alu;
    logic      write_act;
    logic      write_tmp;
    logic      write_flags;
    logic      write_instr;
    alu_op_e   alu_op;
    logic      write_adr;
    pair_sel_e adr_sel;
    logic      write_dout;
  } ctrl_t;

endpackage

// ==== instr_decoder.sv ====
`timescale 1ns/1ps
`include "i8080_settings.svh"

module instr_decoder (
  input  logic [`XLEN-1:0]   instr,
  input  logic [`XLEN-1:0]   flags,
  output i8080_pkg::decoded_t dec
);
  import i8080_pkg::*;

  logic cond_flag;

  always_comb begin
    dec.sss    = instr[2:0];
    dec.ddd    = instr[5:3];
    dec.rp     = instr[5:4];
    dec.alu_op = alu_op_e'({1'b0, instr[5:3]});

    // first match wins, M operand forms fall to nop
    casez (instr)
      8'b01_110_zzz, 8'b01_zzz_110: dec.instr_class = ic_nop;
      8'b01_zzz_zzz:                dec.instr_class = ic_mov;
      8'b00_110_1zz:                dec.instr_class = ic_nop;
      8'b00_zzz_110:                dec.instr_class = ic_mvi;
      8'b00_zz0_001:                dec.instr_class = ic_lxi;
      8'b00_111_010:                dec.instr_class = ic_lda;
      8'b00_110_010:                dec.instr_class = ic_sta;
      8'b10_zzz_110:                dec.instr_class = ic_nop;
      8'b10_zzz_zzz:                dec.instr_class = ic_alu_reg;
      8'b11_zzz_110:                dec.instr_class = ic_alu_imm;
      8'b00_zzz_100:                dec.instr_class = ic_inr;
      8'b00_zzz_101:                dec.instr_class = ic_dcr;
      8'b11_000_011, 8'b11_zzz_010: dec.instr_class = ic_jmp;
      default:                      dec.instr_class = ic_nop;
    endcase

    if (dec.instr_class == ic_inr) dec.alu_op = alu_inr;
    if (dec.instr_class == ic_dcr) dec.alu_op = alu_dcr;

    // cc: flag from bits 5:4, polarity from bit 3
    case (instr[5:4])
      2'b00:   cond_flag = flags[`FLAG_Z];
      2'b01:   cond_flag = flags[`FLAG_C];
      2'b10:   cond_flag = flags[`FLAG_P];
      default: cond_flag = flags[`FLAG_S];
    endcase

    dec.branch_taken = instr[0] | (cond_flag == instr[3]);  // c3 always taken
  end

endmodule

// ==== cycle_control.sv ====
`timescale 1ns/1ps

module cycle_control (
  input  logic                clk,
  input  logic                rst_n,
  input  i8080_pkg::decoded_t dec,
  input  logic                ready,
  output i8080_pkg::ctrl_t    ctrl,
  output logic                sync,
  output logic                dbin,
  output logic                write_n
);
  import i8080_pkg::*;

  tstate_e tstate, tstate_next;
  mcycle_e mcycle, mcycle_next;
  logic    pc_from_wz, pc_from_wz_next;  // taken jump fetches from wz
  logic    mcycle_end, instr_end, stall;
  logic    read_sss, read_ddd, write_ddd;
  logic    bus_phase, write_cycle;

  function automatic reg_sel_e field_reg(input logic [2:0] f);
    return reg_sel_e'({1'b0, f});
  endfunction

  function automatic reg_sel_e pair_half(input logic [1:0] rp, input logic hi);
    reg_sel_e sel;
    case (rp)
      2'd0:    sel = hi ? reg_b : reg_c;
      2'd1:    sel = hi ? reg_d : reg_e;
      2'd2:    sel = hi ? reg_h : reg_l;
      default: sel = hi ? reg_w : reg_z;  // sp halves steered by pair_sel
    endcase
    return sel;
  endfunction

  always_comb begin
    ctrl            = '0;
    ctrl.pair_sel   = pair_pc;
    ctrl.adr_sel    = pair_pc;
    ctrl.alu_op     = dec.alu_op;
    read_sss        = 1'b0;
    read_ddd        = 1'b0;
    write_ddd       = 1'b0;
    mcycle_end      = 1'b0;
    instr_end       = (tstate == tr);
    pc_from_wz_next = 1'b0;

    case ({mcycle, tstate})
      {m1, t1}: begin
        if (pc_from_wz) ctrl.pc_from_wz = 1'b1;
        else ctrl.inc_pair = 1'b1;
      end
      {m1, t2}, {m1, tw}: ctrl.write_instr = 1'b1;
      {m1, t3}: begin
        case (dec.instr_class)
          ic_mov: begin
            read_sss       = 1'b1;
            ctrl.write_tmp = 1'b1;
          end
          ic_alu_reg: begin
            read_sss       = 1'b1;
            ctrl.write_tmp = 1'b1;
            ctrl.write_act = 1'b1;
          end
          ic_alu_imm: ctrl.write_act = 1'b1;
          ic_inr, ic_dcr: begin
            read_ddd       = 1'b1;
            ctrl.write_tmp = 1'b1;
          end
          default: ;
        endcase
      end
      {m1, t4}: begin
        case (dec.instr_class)
          ic_mov: begin
            ctrl.bus_src = bus_tmp;
            write_ddd    = 1'b1;
          end
          ic_alu_reg: begin
            ctrl.a_from_alu  = 1'b1;
            ctrl.write_a     = (dec.alu_op != alu_cmp);
            ctrl.write_flags = 1'b1;
            instr_end        = 1'b1;
          end
          ic_inr, ic_dcr: begin
            ctrl.bus_src     = bus_alu;
            ctrl.write_flags = 1'b1;
            write_ddd        = 1'b1;
          end
          ic_nop: instr_end = 1'b1;
          default: begin  // operand bytes follow at pc
            ctrl.write_adr = 1'b1;
            mcycle_end     = 1'b1;
          end
        endcase
      end
      {m1, t5}: instr_end = 1'b1;
      {m2, t1}, {m3, t1}: ctrl.inc_pair = 1'b1;
      {m2, t2}, {m2, tw}, {m3, t2}, {m3, tw}: begin
        case (dec.instr_class)
          ic_mvi: write_ddd = 1'b1;
          ic_alu_imm: ctrl.write_tmp = 1'b1;
          ic_lxi: begin
            ctrl.reg_sel   = pair_half(dec.rp, mcycle == m3);
            ctrl.pair_sel  = pair_sel_e'({1'b0, dec.rp});
            ctrl.write_reg = 1'b1;
          end
          default: begin  // address operand into wz
            ctrl.reg_sel   = (mcycle == m3) ? reg_w : reg_z;
            ctrl.write_reg = 1'b1;
          end
        endcase
      end
      {m2, t3}: begin
        mcycle_end = 1'b1;
        case (dec.instr_class)
          ic_mvi: instr_end = 1'b1;
          ic_alu_imm: begin
            ctrl.a_from_alu  = 1'b1;
            ctrl.write_a     = (dec.alu_op != alu_cmp);
            ctrl.write_flags = 1'b1;
            instr_end        = 1'b1;
          end
          default: ctrl.write_adr = 1'b1;
        endcase
      end
      {m3, t3}: begin
        mcycle_end = 1'b1;
        case (dec.instr_class)
          ic_lda, ic_sta: begin
            ctrl.write_adr = 1'b1;
            ctrl.adr_sel   = pair_wz;
          end
          ic_jmp: begin
            pc_from_wz_next = dec.branch_taken;
            instr_end       = 1'b1;
          end
          default: instr_end = 1'b1;
        endcase
      end
      {m4, t1}: begin
        if (dec.instr_class == ic_sta) begin
          ctrl.bus_src    = bus_a;
          ctrl.write_dout = 1'b1;
        end
      end
      {m4, t2}, {m4, tw}: ctrl.write_a = (dec.instr_class == ic_lda);
      {m4, t3}: instr_end = 1'b1;
      default: ;
    endcase

    if (read_sss || read_ddd) begin
      ctrl.reg_sel = field_reg(read_sss ? dec.sss : dec.ddd);
      ctrl.bus_src = (ctrl.reg_sel == reg_a) ? bus_a : bus_reg;
    end
    if (write_ddd && dec.ddd == 3'b111) begin
      ctrl.write_a = 1'b1;
    end else if (write_ddd) begin
      ctrl.reg_sel   = field_reg(dec.ddd);
      ctrl.write_reg = 1'b1;
    end
    if (instr_end) begin  // next fetch address
      ctrl.write_adr = 1'b1;
      ctrl.adr_sel   = pc_from_wz_next ? pair_wz : pair_pc;
    end

    stall = (tstate == t2 || tstate == tw) && !ready;
    if (stall) ctrl = '0;  // wait state commits nothing

    mcycle_next = mcycle;
    if (stall) begin
      tstate_next = tw;
    end else if (instr_end) begin
      tstate_next = t1;
      mcycle_next = m1;
    end else if (mcycle_end) begin
      tstate_next = t1;
      mcycle_next = mcycle_e'(mcycle + 2'd1);
    end else begin
      case (tstate)
        t1:      tstate_next = t2;
        t2, tw:  tstate_next = t3;
        t3:      tstate_next = t4;
        t4:      tstate_next = t5;
        default: tstate_next = t1;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tstate     <= tr;
      mcycle     <= m1;
      pc_from_wz <= 1'b0;
    end else begin
      tstate     <= tstate_next;
      mcycle     <= mcycle_next;
      pc_from_wz <= pc_from_wz_next;
    end
  end

  assign bus_phase   = (tstate == t2) || (tstate == tw);
  assign write_cycle = (mcycle == m4) && (dec.instr_class == ic_sta);  // only sta writes
  assign sync        = (tstate == t1);
  assign dbin        = bus_phase && !write_cycle;
  assign write_n     = !(bus_phase && write_cycle);

  a_bus_dir: assert property (@(posedge clk) disable iff (!rst_n)
    sync |=> (dbin ^ !write_n));
  a_tw_entry: assert property (@(posedge clk) disable iff (!rst_n)
    tstate == tw |-> $past(tstate) inside {t2, tw});

endmodule

// ==== alu.sv ====
`timescale 1ns/1ps
`include "i8080_settings.svh"

module alu (
  input  logic [`XLEN-1:0] op_a,
  input  logic [`XLEN-1:0] op_b,
  input  logic [`XLEN-1:0] flags_in,
  input  i8080_pkg::alu_op_e op,
  output logic [`XLEN-1:0] result,
  output logic [`XLEN-1:0] flags_out
);
  import i8080_pkg::*;

  logic [`XLEN:0] sum;  // carry or borrow in msb
  logic           carry_in;
  logic           sub_op;

  always_comb begin
    sub_op   = (op == alu_sub) || (op == alu_sbb) || (op == alu_cmp);
    carry_in = ((op == alu_adc) || (op == alu_sbb)) && flags_in[`FLAG_C];
    if (sub_op) sum = {1'b0, op_a} - {1'b0, op_b} - carry_in;
    else sum = {1'b0, op_a} + {1'b0, op_b} + carry_in;

    flags_out = flags_in;
    result    = sum[`XLEN-1:0];
    case (op)
      alu_ana: result = op_a & op_b;
      alu_xra: result = op_a ^ op_b;
      alu_ora: result = op_a | op_b;
      alu_inr: result = op_b + 1'b1;  // carry untouched
      alu_dcr: result = op_b - 1'b1;
      default: flags_out[`FLAG_C] = sum[`XLEN];
    endcase
    if (op == alu_ana || op == alu_xra || op == alu_ora) flags_out[`FLAG_C] = 1'b0;

    flags_out[`FLAG_Z] = (result == '0);
    flags_out[`FLAG_S] = result[`XLEN-1];
    flags_out[`FLAG_P] = ~^result;  // set on even parity
  end

endmodule

// ==== register_file.sv ====
`timescale 1ns/1ps
`include "i8080_settings.svh"

module register_file (
  input  logic                 clk,
  input  logic                 rst_n,
  input  i8080_pkg::reg_sel_e  reg_sel,
  input  i8080_pkg::pair_sel_e pair_sel,
  input  logic [`XLEN-1:0]     wdata,
  input  logic                 write_reg,
  input  logic                 inc_pair,
  input  logic                 pc_from_wz,
  output logic [`XLEN-1:0]     rdata,
  output logic [`ALEN-1:0]     pair_data
);
  import i8080_pkg::*;

  logic [`XLEN-1:0] b, c, d, e, h, l, w, z;
  logic [`ALEN-1:0] sp, pc;
  logic [`ALEN-1:0] pair_inc, wz_inc;

  always_comb begin
    case (reg_sel)
      reg_b:   rdata = b;
      reg_c:   rdata = c;
      reg_d:   rdata = d;
      reg_e:   rdata = e;
      reg_h:   rdata = h;
      reg_l:   rdata = l;
      reg_w:   rdata = w;
      reg_z:   rdata = z;
      default: rdata = '0;  // a lives in the datapath
    endcase

    case (pair_sel)
      pair_bc: pair_data = {b, c};
      pair_de: pair_data = {d, e};
      pair_hl: pair_data = {h, l};
      pair_sp: pair_data = sp;
      pair_wz: pair_data = {w, z};
      default: pair_data = pc;
    endcase
  end

  assign pair_inc = pair_data + 1'b1;
  assign wz_inc   = {w, z} + 1'b1;  // byte after the jump target

  always_ff @(posedge clk) begin
    if (write_reg && pair_sel == pair_sp) begin
      // lxi sp: w selects the high half, z the low
      if (reg_sel == reg_w) sp[`ALEN-1:`XLEN] <= wdata;
      else sp[`XLEN-1:0] <= wdata;
    end else if (write_reg) begin
      case (reg_sel)
        reg_b:   b <= wdata;
        reg_c:   c <= wdata;
        reg_d:   d <= wdata;
        reg_e:   e <= wdata;
        reg_h:   h <= wdata;
        reg_l:   l <= wdata;
        reg_w:   w <= wdata;
        reg_z:   z <= wdata;
        default: ;
      endcase
    end else if (inc_pair && pair_sel == pair_wz) begin
      {w, z} <= pair_inc;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) pc <= '0;
    else if (pc_from_wz) pc <= wz_inc;
    else if (inc_pair && pair_sel == pair_pc) pc <= pair_inc;
  end

  a_port_excl: assert property (@(posedge clk) disable iff (!rst_n) !(write_reg && inc_pair));

endmodule

// ==== datapath.sv ====
`timescale 1ns/1ps
`include "i8080_settings.svh"

module datapath (
  input  logic             clk,
  input  logic             rst_n,
  input  i8080_pkg::ctrl_t ctrl,
  input  logic [`XLEN-1:0] data_in,
  output logic [`XLEN-1:0] instr,
  output logic [`XLEN-1:0] flags,
  output logic [`ALEN-1:0] addr,
  output logic [`XLEN-1:0] data_out
);
  import i8080_pkg::*;

  logic [`XLEN-1:0] bus;  // internal bus
  logic [`XLEN-1:0] a, act, tmp;
  logic [`XLEN-1:0] reg_rdata, alu_result, alu_flags;
  logic [`ALEN-1:0] pair_data;
  pair_sel_e        rf_pair_sel;

  // address latch reads its own pair selection
  assign rf_pair_sel = ctrl.write_adr ? ctrl.adr_sel : ctrl.pair_sel;

  always_comb begin
    case (ctrl.bus_src)
      bus_reg: bus = reg_rdata;
      bus_a:   bus = a;
      bus_tmp: bus = tmp;
      bus_alu: bus = alu_result;
      default: bus = data_in;
    endcase
  end

  alu u_alu (
    .op_a     (act),
    .op_b     (tmp),
    .flags_in (flags),
    .op       (ctrl.alu_op),
    .result   (alu_result),
    .flags_out(alu_flags)
  );

  register_file u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .reg_sel   (ctrl.reg_sel),
    .pair_sel  (rf_pair_sel),
    .wdata     (bus),
    .write_reg (ctrl.write_reg),
    .inc_pair  (ctrl.inc_pair),
    .pc_from_wz(ctrl.pc_from_wz),
    .rdata     (reg_rdata),
    .pair_data (pair_data)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) flags <= `FLAGS_RESET;
    else if (ctrl.write_flags) flags <= alu_flags;
  end

  always_ff @(posedge clk) begin
    if (ctrl.write_a) a <= ctrl.a_from_alu ? alu_result : bus;
    if (ctrl.write_act) act <= a;  // act only ever takes a
    if (ctrl.write_tmp) tmp <= bus;
    if (ctrl.write_instr) instr <= bus;
    if (ctrl.write_adr) addr <= pair_data;
    if (ctrl.write_dout) data_out <= bus;
  end

endmodule

// ==== i8080.sv ====
`timescale 1ns/1ps
`include "i8080_settings.svh"

module i8080 (
  input  logic             clk,
  input  logic             rst_n,
  input  logic [`XLEN-1:0] data_in,
  input  logic             ready,
  output logic [`XLEN-1:0] data_out,
  output logic [`ALEN-1:0] addr,
  output logic             sync,
  output logic             dbin,
  output logic             write_n
);
  import i8080_pkg::*;

  decoded_t         dec;
  ctrl_t            ctrl;
  logic [`XLEN-1:0] instr;
  logic [`XLEN-1:0] flags;

  instr_decoder u_dec (
    .instr(instr),
    .flags(flags),
    .dec  (dec)
  );

  cycle_control u_ctl (
    .clk    (clk),
    .rst_n  (rst_n),
    .dec    (dec),
    .ready  (ready),
    .ctrl   (ctrl),
    .sync   (sync),
    .dbin   (dbin),
    .write_n(write_n)
  );

  datapath u_dp (
    .clk     (clk),
    .rst_n   (rst_n),
    .ctrl    (ctrl),
    .data_in (data_in),
    .instr   (instr),
    .flags   (flags),
    .addr    (addr),
    .data_out(data_out)
  );

endmodule

// ==== tb_i8080.sv ====
`timescale 1ns/1ps
`include "i8080_settings.svh"

module tb_i8080;

  localparam int MAX_CLK = 4000;  // per test clock budget
  localparam int WATCH_NS = 6 * (MAX_CLK + 10) * 20 * 2;
  localparam logic [15:0] MARK = 16'hfff0;

  logic clk, rst_n, ready, sync, dbin, write_n;
  logic [7:0] data_in, data_out;
  logic [15:0] addr;
  logic [7:0] mem [0:65535];
  logic [7:0] mr [0:7];  // model registers with a at index 7
  logic fc, fz, fs, fp;
  logic [15:0] pc_e, res_adr, stop_adr;
  logic [15:0] chk_adr [$];
  logic [7:0] chk_val [$];
  integer seed = 56;
  int exp_clk, errors, test_errs, tests_run, tests_failed;
  int clk_count, waits, first_clk, done_interval, done_waits;
  bit wait_mode, running, done, first_seen, stop_seen;

  i8080 i8080_i (.clk(clk), .rst_n(rst_n), .data_in(data_in), .ready(ready),
    .data_out(data_out), .addr(addr), .sync(sync), .dbin(dbin), .write_n(write_n));

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    clk_count = 0;
    forever @(posedge clk) clk_count = clk_count + 1;
  end

  // memory model and bus monitor driving inputs on the falling edge
  initial begin
    data_in = 8'h00;
    ready = 1'b1;
    forever begin
      @(negedge clk);
      ready = wait_mode ? (($random(seed) & 3) != 0) : 1'b1;
      if (rst_n && running) begin
        if (sync) begin
          if (!first_seen) begin
            first_seen = 1'b1;
            first_clk = clk_count;
            if (addr !== 16'h0000) begin
              $display("error: %0t addr got %h expected 0000", $time, addr);
              test_errs++;
            end
          end
          if (addr == stop_adr && !stop_seen) begin  // fetch of the marker store
            stop_seen = 1'b1;
            done_interval = clk_count - first_clk;
            done_waits = waits;
          end
        end
        if ((dbin || !write_n) && !ready) waits++;  // next state is tw
        if (!write_n) begin
          mem[addr] = data_out;
          if (addr == MARK) done = 1'b1;
        end
      end
      data_in = mem[addr];
    end
  end

  task automatic put(input logic [7:0] b);
    mem[pc_e] = b;
    pc_e = pc_e + 16'd1;
  endtask

  task automatic put_adr(input logic [15:0] a16);
    put(a16[7:0]);
    put(a16[15:8]);
  endtask

  task automatic set_zsp(input logic [7:0] r);
    fz = (r == 8'h00);
    fs = r[7];
    fp = ~^r;  // even parity
  endtask

  task automatic model_alu(input logic [2:0] op, input logic [7:0] b);
    logic [8:0] s;
    logic [7:0] a;
    a = mr[7];
    case (op)
      3'd0: s = {1'b0, a} + {1'b0, b};
      3'd1: s = {1'b0, a} + {1'b0, b} + {8'd0, fc};
      3'd2, 3'd7: s = {1'b0, a} - {1'b0, b};
      3'd3: s = {1'b0, a} - {1'b0, b} - {8'd0, fc};
      3'd4: s = {1'b0, a & b};
      3'd5: s = {1'b0, a ^ b};
      default: s = {1'b0, a | b};
    endcase
    fc = (op[2] == 1'b0 || op == 3'd7) ? s[8] : 1'b0;
    set_zsp(s[7:0]);
    if (op != 3'd7) mr[7] = s[7:0];
  endtask

  task automatic load_imm(input logic [2:0] d, input logic [7:0] imm);
    put({2'b00, d, 3'b110});
    put(imm);
    mr[d] = imm;
    exp_clk += 7;
  endtask

  task automatic copy_reg(input logic [2:0] d, input logic [2:0] s);
    put({2'b01, d, s});
    mr[d] = mr[s];
    exp_clk += 5;
  endtask

  task automatic reg_alu_op(input logic [2:0] op, input logic [2:0] s);
    put({2'b10, op, s});
    model_alu(op, mr[s]);
    exp_clk += 4;
  endtask

  task automatic imm_alu_op(input logic [2:0] op, input logic [7:0] imm);
    put({2'b11, op, 3'b110});
    put(imm);
    model_alu(op, imm);
    exp_clk += 7;
  endtask

  task automatic step_reg(input logic [2:0] d, input bit dec_op);
    put({2'b00, d, 2'b10, dec_op});
    mr[d] = dec_op ? mr[d] - 8'd1 : mr[d] + 8'd1;
    set_zsp(mr[d]);  // carry stays
    exp_clk += 5;
  endtask

  task automatic load_pair(input logic [1:0] rp, input logic [15:0] v);
    put({2'b00, rp, 4'b0001});
    put_adr(v);
    if (rp != 2'd3) begin
      mr[{rp, 1'b0}] = v[15:8];
      mr[{rp, 1'b1}] = v[7:0];
    end
    exp_clk += 10;
  endtask

  task automatic load_acc(input logic [15:0] a16);
    put(8'h3a);
    put_adr(a16);
    mr[7] = mem[a16];
    exp_clk += 13;
  endtask

  task automatic store_result();
    put(8'h32);
    put_adr(res_adr);
    chk_adr.push_back(res_adr);
    chk_val.push_back(mr[7]);
    res_adr = res_adr + 16'd1;
    exp_clk += 13;
  endtask

  // jcc over a block storing 11 to a target block storing 22
  task automatic branch_block(input logic [2:0] cc);
    logic flag;
    logic taken;
    logic [15:0] j;
    case (cc[2:1])
      2'd0: flag = fz;
      2'd1: flag = fc;
      2'd2: flag = fp;
      default: flag = fs;
    endcase
    taken = (flag == cc[0]);
    j = pc_e;
    put({2'b11, cc, 3'b010});
    put_adr(j + 16'd11);
    put(8'h3e);
    put(8'h11);
    put(8'h32);
    put_adr(res_adr);
    put(8'hc3);
    put_adr(j + 16'd16);
    put(8'h3e);
    put(8'h22);
    put(8'h32);
    put_adr(res_adr);
    mr[7] = taken ? 8'h22 : 8'h11;
    chk_adr.push_back(res_adr);
    chk_val.push_back(mr[7]);
    res_adr = res_adr + 16'd1;
    exp_clk += taken ? 30 : 40;
  endtask

  task automatic begin_prog();
    @(negedge clk);
    rst_n = 1'b0;
    running = 1'b0;
    for (int i = 0; i < 65536; i++) mem[i] = 8'(i) ^ 8'(i >> 8);
    for (int i = 0; i < 8; i++) mr[i] = 8'h00;
    {fc, fz, fs, fp} = 4'b0000;
    pc_e = 16'h0000;
    res_adr = 16'h8000;
    exp_clk = 0;
    chk_adr.delete();
    chk_val.delete();
  endtask

  task automatic finish_prog(input string name);
    logic [15:0] j;
    int n;
    stop_adr = pc_e;
    put(8'h32);
    put_adr(MARK);
    j = pc_e;
    put(8'hc3);  // park in a loop
    put_adr(j);
    waits = 0;
    done = 1'b0;
    first_seen = 1'b0;
    stop_seen = 1'b0;
    test_errs = 0;
    running = 1'b1;
    repeat (2) begin
      @(negedge clk);
      if (dbin !== 1'b0 || write_n !== 1'b1) begin
        $display("%0t: bus strobes active during reset", $time);
        test_errs++;
      end
    end
    rst_n = 1'b1;
    n = 0;
    while (!done && n < MAX_CLK) begin
      @(posedge clk);
      n++;
    end
    if (!done) begin
      $display("%0t: marker store never seen in test %s", $time, name);
      test_errs++;
    end else begin
      foreach (chk_adr[k]) begin
        if (mem[chk_adr[k]] !== chk_val[k]) begin
          $display("error: %0t mem[%h] got %h expected %h", $time, chk_adr[k],
            mem[chk_adr[k]], chk_val[k]);
          test_errs++;
        end
      end
      if (done_interval != exp_clk + done_waits) begin
        $display("error: %0t sync interval got %0d expected %0d", $time, done_interval,
          exp_clk + done_waits);
        test_errs++;
      end
    end
    running = 1'b0;
    errors += test_errs;
    tests_run++;
    if (test_errs != 0) tests_failed++;
    $display("test %s: %0d errors", name, test_errs);
  endtask

  task automatic reset_test();
    begin_prog();
    load_imm(3'd7, 8'ha5);
    store_result();
    finish_prog("reset");
  endtask

  task automatic moves_test();
    begin_prog();
    for (int i = 0; i < 6; i++) load_imm(3'(i), 8'(8'h21 * (i + 1)));
    for (int i = 0; i < 6; i++) begin
      copy_reg(3'd7, 3'(i));
      store_result();
    end
    load_imm(3'd0, 8'h3c);
    for (int i = 1; i < 6; i++) copy_reg(3'(i), 3'(i - 1));  // b through l
    copy_reg(3'd7, 3'd5);
    store_result();
    finish_prog("moves");
  endtask

  task automatic alu_test(input string name);
    begin_prog();
    for (int i = 0; i < 8; i++) begin
      load_imm(3'd7, 8'(8'h35 * (i + 1)));
      imm_alu_op(3'd0, 8'hc8);  // carry for adc and sbb
      load_imm(3'd2, 8'(8'h5b + i * 19));
      reg_alu_op(3'(i), 3'd2);
      store_result();
      imm_alu_op(3'(i), 8'(8'h9c - i * 7));
      store_result();
    end
    finish_prog(name);
  endtask

  task automatic incdec_test();
    begin_prog();
    mem[16'h9000] = 8'hff;
    load_imm(3'd7, 8'hff);
    imm_alu_op(3'd0, 8'h01);
    load_acc(16'h9000);
    step_reg(3'd7, 1'b0);  // wraps to 00
    store_result();
    branch_block(3'd3);
    branch_block(3'd1);
    load_imm(3'd1, 8'h00);
    step_reg(3'd1, 1'b1);
    copy_reg(3'd7, 3'd1);
    store_result();
    branch_block(3'd2);
    branch_block(3'd7);
    finish_prog("incdec");
  endtask

  task automatic jumps_test();
    begin_prog();
    load_pair(2'd0, 16'h1234);
    load_pair(2'd1, 16'hbeef);
    load_pair(2'd2, 16'h5a0f);
    load_pair(2'd3, 16'h7ffe);
    for (int i = 0; i < 6; i++) begin
      copy_reg(3'd7, 3'(i));
      store_result();
    end
    for (int s = 0; s < 4; s++) begin
      case (s)
        0: begin
          load_imm(3'd7, 8'h00);
          reg_alu_op(3'd6, 3'd7);
        end
        1: begin
          load_imm(3'd7, 8'hff);
          imm_alu_op(3'd0, 8'h01);
        end
        2: begin
          load_imm(3'd7, 8'h7f);
          imm_alu_op(3'd0, 8'h80);
        end
        default: begin
          load_imm(3'd7, 8'h01);
          reg_alu_op(3'd6, 3'd7);
        end
      endcase
      for (int cc = 0; cc < 8; cc++) branch_block(3'(cc));
    end
    finish_prog("jumps");
  endtask

  initial begin
    #(WATCH_NS);
    $display("watchdog expired before the tests finished");
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    rst_n = 1'b0;
    wait_mode = 1'b0;
    running = 1'b0;
    done = 1'b0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    reset_test();
    moves_test();
    alu_test("alu");
    incdec_test();
    jumps_test();
    wait_mode = 1'b1;
    alu_test("waits");
    wait_mode = 1'b0;
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+.
i8080_pkg.sv
instr_decoder.sv
cycle_control.sv
alu.sv
register_file.sv
datapath.sv
i8080.sv
tb_i8080.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_i8080
OBJ_DIR ?= obj_dir
FILELIST ?= src.f
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= ALL CHECKS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
